//--- logic/alu.sv
`timescale 1ns/1ps
`include "pipe_cfg.svh"

module alu (
    input  alu_pkg::alu_op_t alu_op,
    input  pipe_pkg::word_t  src1,
    input  pipe_pkg::word_t  src2,
    output pipe_pkg::word_t  result
);
    import alu_pkg::*;
    import pipe_pkg::*;

    localparam int MSB = `PIPE_XLEN - 1;

    logic       use_sub;
    word_t      add_b;
    word_t      add_sum;
    logic       add_cout;
    logic       slt_bit;
    logic       sltu_bit;
    logic [4:0] shamt;

    // one adder shared by add, sub and both compares
    assign use_sub = alu_op[OP_SUB] | alu_op[OP_SLT] | alu_op[OP_SLTU];
    assign add_b   = use_sub ? ~src2 : src2;
    assign {add_cout, add_sum} = src1 + add_b + {{MSB{1'b0}}, use_sub};

    // signed: differing signs decide directly, else sign of the difference
    assign slt_bit  = (src1[MSB] & ~src2[MSB])
                    | (~(src1[MSB] ^ src2[MSB]) & add_sum[MSB]);
    // no carry out of a - b means a borrow
    assign sltu_bit = ~add_cout;

    assign shamt = src2[4:0];

    always_comb begin
        result = ({`PIPE_XLEN{alu_op[OP_ADD] | alu_op[OP_SUB]}} & add_sum)
               | ({`PIPE_XLEN{alu_op[OP_SLT]}}  & {{MSB{1'b0}}, slt_bit})
               | ({`PIPE_XLEN{alu_op[OP_SLTU]}} & {{MSB{1'b0}}, sltu_bit})
               | ({`PIPE_XLEN{alu_op[OP_AND]}}  & (src1 & src2))
               | ({`PIPE_XLEN{alu_op[OP_OR]}}   & (src1 | src2))
               | ({`PIPE_XLEN{alu_op[OP_NOR]}}  & ~(src1 | src2))
               | ({`PIPE_XLEN{alu_op[OP_XOR]}}  & (src1 ^ src2))
               | ({`PIPE_XLEN{alu_op[OP_SLL]}}  & (src1 << shamt))
               | ({`PIPE_XLEN{alu_op[OP_SRL]}}  & (src1 >> shamt))
               | ({`PIPE_XLEN{alu_op[OP_SRA]}}  & word_t'($signed(src1) >>> shamt))
               | ({`PIPE_XLEN{alu_op[OP_LUI]}}  & src2);
    end

endmodule

//--- logic/alu_pkg.sv
`include "pipe_cfg.svh"

package alu_pkg;

    // one-hot operation select, exactly one bit set per valid op
    typedef logic [`PIPE_ALU_OPS-1:0] alu_op_t;

    // bit positions within alu_op_t
    localparam int OP_ADD  = 0;
    localparam int OP_SUB  = 1;
    localparam int OP_SLT  = 2;
    localparam int OP_SLTU = 3;
    localparam int OP_AND  = 4;
    localparam int OP_OR   = 5;
    localparam int OP_NOR  = 6;
    localparam int OP_XOR  = 7;
    localparam int OP_SLL  = 8;
    localparam int OP_SRL  = 9;
    localparam int OP_SRA  = 10;
    // upper immediate already shifted by decode, passed through on src2
    localparam int OP_LUI  = 11;

endpackage

//--- logic/data_ram.sv
`timescale 1ns/1ps
`include "pipe_cfg.svh"

module data_ram (
    input  logic            clk,
    input  logic            en,
    input  logic [3:0]      we,
    input  pipe_pkg::word_t addr,
    input  pipe_pkg::word_t wdata,
    output pipe_pkg::word_t rdata
);
    import pipe_pkg::*;

    localparam int AW = $clog2(`PIPE_DMEM_WORDS);

    word_t         mem [0:`PIPE_DMEM_WORDS-1];
    logic [AW-1:0] idx;

    // word aligned, upper address bits ignored
    assign idx = addr[AW+1:2];

    // ram powers up cleared
    initial begin
        for (int i = 0; i < `PIPE_DMEM_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (en) begin
            for (int b = 0; b < 4; b++) begin
                if (we[b]) begin
                    mem[idx][8*b +: 8] <= wdata[8*b +: 8];
                end
            end
            // read-before-write, rdata holds while en is low
            rdata <= mem[idx];
        end
    end

endmodule

//--- logic/es_ms_if.sv
`timescale 1ns/1ps

interface es_ms_if;
    import pipe_pkg::*;

    // handshake
    logic      valid;
    logic      allowin;

    // record, flags already qualified by valid
    logic      res_from_mem;
    logic      rf_we;
    reg_addr_t rf_waddr;
    word_t     alu_result;
    pc_t       pc;

    modport ex (
        output valid,
        output res_from_mem,
        output rf_we,
        output rf_waddr,
        output alu_result,
        output pc,
        input  allowin
    );

    modport mem (
        input  valid,
        input  res_from_mem,
        input  rf_we,
        input  rf_waddr,
        input  alu_result,
        input  pc,
        output allowin
    );

endinterface

//--- logic/ex_stage.sv
`timescale 1ns/1ps

module ex_stage (
    input  logic                 clk,
    input  logic                 resetn,
    input  logic                 in_valid,
    output logic                 in_allowin,
    input  alu_pkg::alu_op_t     in_alu_op,
    input  pipe_pkg::word_t      in_src1,
    input  pipe_pkg::word_t      in_src2,
    input  pipe_pkg::word_t      in_rkd_value,
    input  logic                 in_res_from_mem,
    input  logic                 in_mem_we,
    input  logic                 in_rf_we,
    input  pipe_pkg::reg_addr_t  in_rf_waddr,
    input  pipe_pkg::pc_t        in_pc,
    es_ms_if.ex                  es2ms,
    output logic                 dmem_en,
    output logic [3:0]           dmem_we,
    output pipe_pkg::word_t      dmem_addr,
    output pipe_pkg::word_t      dmem_wdata
);
    import alu_pkg::*;
    import pipe_pkg::*;

    logic      es_valid;
    logic      es_go;
    alu_op_t   es_alu_op;
    word_t     es_src1;
    word_t     es_src2;
    word_t     es_rkd_value;
    logic      es_res_from_mem;
    logic      es_mem_we;
    logic      es_rf_we;
    reg_addr_t es_rf_waddr;
    pc_t       es_pc;
    word_t     es_alu_result;

    // work completes in zero cycles, so only downstream space matters
    assign in_allowin = ~es_valid | es2ms.allowin;
    assign es_go      = es_valid & es2ms.allowin;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            es_valid <= 1'b0;
        end else if (in_allowin) begin
            es_valid <= in_valid;
        end
    end

    // operation fields, loaded on acceptance
    always_ff @(posedge clk) begin
        if (in_valid && in_allowin) begin
            es_alu_op       <= in_alu_op;
            es_src1         <= in_src1;
            es_src2         <= in_src2;
            es_rkd_value    <= in_rkd_value;
            es_res_from_mem <= in_res_from_mem;
            es_mem_we       <= in_mem_we;
            es_rf_we        <= in_rf_we;
            es_rf_waddr     <= in_rf_waddr;
            es_pc           <= in_pc;
        end
    end

    alu u_alu (
        .alu_op (es_alu_op),
        .src1   (es_src1),
        .src2   (es_src2),
        .result (es_alu_result)
    );

    assign es2ms.valid        = es_valid;
    assign es2ms.res_from_mem = es_valid & es_res_from_mem;
    // a store never writes the register file
    assign es2ms.rf_we        = es_valid & es_rf_we & ~es_mem_we;
    assign es2ms.rf_waddr     = es_rf_waddr;
    assign es2ms.alu_result   = es_alu_result;
    assign es2ms.pc           = es_pc;

    // ram access only on the transfer edge, so a stall cannot repeat it
    assign dmem_en    = es_go & (es_res_from_mem | es_mem_we);
    assign dmem_we    = {4{es_go & es_mem_we}};
    assign dmem_addr  = es_alu_result;
    assign dmem_wdata = es_rkd_value;

    // each store reaches the ram only once
    a_write_once: assert property (@(posedge clk) disable iff (!resetn)
        (dmem_we != 4'b0) |=> (dmem_we == 4'b0) || $past(in_valid && in_allowin))
        else $error("ex_stage: ram written twice for one store");

    // a refusing stage stays full with its operation
    a_full_holds: assert property (@(posedge clk) disable iff (!resetn)
        !in_allowin |=> (es_valid && $stable(es_pc)))
        else $error("ex_stage: held operation lost while input refused");

endmodule

//--- logic/exec_pipe_top.sv
`timescale 1ns/1ps

module exec_pipe_top (
    input  logic                clk,
    input  logic                resetn,
    input  logic                in_valid,
    output logic                in_allowin,
    input  alu_pkg::alu_op_t    in_alu_op,
    input  pipe_pkg::word_t     in_src1,
    input  pipe_pkg::word_t     in_src2,
    input  pipe_pkg::word_t     in_rkd_value,
    input  logic                in_res_from_mem,
    input  logic                in_mem_we,
    input  logic                in_rf_we,
    input  pipe_pkg::reg_addr_t in_rf_waddr,
    input  pipe_pkg::pc_t       in_pc,
    output logic                wb_valid,
    input  logic                wb_ready,
    output logic                wb_rf_we,
    output pipe_pkg::reg_addr_t wb_rf_waddr,
    output pipe_pkg::word_t     wb_rf_wdata,
    output pipe_pkg::pc_t       wb_pc
);
    import pipe_pkg::*;

    logic       dmem_en;
    logic [3:0] dmem_we;
    word_t      dmem_addr;
    word_t      dmem_wdata;
    word_t      dmem_rdata;

    es_ms_if es2ms ();

    ex_stage u_ex (
        .clk             (clk),
        .resetn          (resetn),
        .in_valid        (in_valid),
        .in_allowin      (in_allowin),
        .in_alu_op       (in_alu_op),
        .in_src1         (in_src1),
        .in_src2         (in_src2),
        .in_rkd_value    (in_rkd_value),
        .in_res_from_mem (in_res_from_mem),
        .in_mem_we       (in_mem_we),
        .in_rf_we        (in_rf_we),
        .in_rf_waddr     (in_rf_waddr),
        .in_pc           (in_pc),
        .es2ms           (es2ms.ex),
        .dmem_en         (dmem_en),
        .dmem_we         (dmem_we),
        .dmem_addr       (dmem_addr),
        .dmem_wdata      (dmem_wdata)
    );

    data_ram u_ram (
        .clk   (clk),
        .en    (dmem_en),
        .we    (dmem_we),
        .addr  (dmem_addr),
        .wdata (dmem_wdata),
        .rdata (dmem_rdata)
    );

    mem_stage u_mem (
        .clk         (clk),
        .resetn      (resetn),
        .es2ms       (es2ms.mem),
        .dmem_rdata  (dmem_rdata),
        .wb_valid    (wb_valid),
        .wb_ready    (wb_ready),
        .wb_rf_we    (wb_rf_we),
        .wb_rf_waddr (wb_rf_waddr),
        .wb_rf_wdata (wb_rf_wdata),
        .wb_pc       (wb_pc)
    );

endmodule

//--- logic/mem_stage.sv
`timescale 1ns/1ps

module mem_stage (
    input  logic                clk,
    input  logic                resetn,
    es_ms_if.mem                es2ms,
    input  pipe_pkg::word_t     dmem_rdata,
    output logic                wb_valid,
    input  logic                wb_ready,
    output logic                wb_rf_we,
    output pipe_pkg::reg_addr_t wb_rf_waddr,
    output pipe_pkg::word_t     wb_rf_wdata,
    output pipe_pkg::pc_t       wb_pc
);
    import pipe_pkg::*;

    logic      ms_valid;
    logic      ms_res_from_mem;
    logic      ms_rf_we;
    reg_addr_t ms_rf_waddr;
    word_t     ms_alu_result;
    pc_t       ms_pc;

    // wb_ready acts as the writeback stage allowin
    assign es2ms.allowin = ~ms_valid | wb_ready;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            ms_valid <= 1'b0;
        end else if (es2ms.allowin) begin
            ms_valid <= es2ms.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (es2ms.valid && es2ms.allowin) begin
            ms_res_from_mem <= es2ms.res_from_mem;
            ms_rf_we        <= es2ms.rf_we;
            ms_rf_waddr     <= es2ms.rf_waddr;
            ms_alu_result   <= es2ms.alu_result;
            ms_pc           <= es2ms.pc;
        end
    end

    assign wb_valid    = ms_valid;
    assign wb_rf_we    = ms_valid & ms_rf_we;
    assign wb_rf_waddr = ms_rf_waddr;
    // load data was registered by the ram on the same transfer edge
    assign wb_rf_wdata = ms_res_from_mem ? dmem_rdata : ms_alu_result;
    assign wb_pc       = ms_pc;

    // also relies on the ram not being re-enabled during a stall
    a_wb_stable: assert property (@(posedge clk) disable iff (!resetn)
        (wb_valid && !wb_ready) |=>
            (wb_valid && $stable({wb_rf_we, wb_rf_waddr, wb_rf_wdata, wb_pc})))
        else $error("mem_stage: writeback record changed while stalled");

endmodule

//--- logic/pipe_cfg.svh
`ifndef PIPE_CFG_SVH
`define PIPE_CFG_SVH

// datapath word width
`define PIPE_XLEN 32

// register file address width
`define PIPE_RADDR_W 5

// one bit per alu operation
`define PIPE_ALU_OPS 12

// data ram depth in words, indexed by addr[9:2]
`define PIPE_DMEM_WORDS 256

`endif

//--- logic/pipe_pkg.sv
`include "pipe_cfg.svh"

package pipe_pkg;

    // data word as seen by alu, ram and writeback
    typedef logic [`PIPE_XLEN-1:0] word_t;

    // destination register number
    typedef logic [`PIPE_RADDR_W-1:0] reg_addr_t;

    // instruction address carried down the pipe for tracing
    typedef logic [`PIPE_XLEN-1:0] pc_t;

endpackage

//--- verif/tb_exec_pipe.sv
`timescale 1ns/1ps
`include "pipe_cfg.svh"

module tb_exec_pipe;
    import alu_pkg::*;
    import pipe_pkg::*;

    localparam int CLK_NS  = 10;
    localparam int N_ALU   = 60;
    localparam int N_STORE = 16;
    localparam int N_LOAD  = 32;
    localparam int N_MIX   = 100;
    // the final store/load pair adds two
    localparam int N_OPS   = N_ALU + N_STORE + N_LOAD + N_MIX + 2;
    localparam alu_op_t ADD_OP = alu_op_t'(1) << OP_ADD;

    typedef struct packed {
        logic      rf_we;
        reg_addr_t waddr;
        word_t     wdata;
        pc_t       pc;
        logic      fixed_lat;
        int        acc_cyc;
    } wb_rec_t;

    logic      clk;
    logic      resetn;
    logic      in_valid;
    logic      in_allowin;
    alu_op_t   in_alu_op;
    word_t     in_src1;
    word_t     in_src2;
    word_t     in_rkd_value;
    logic      in_res_from_mem;
    logic      in_mem_we;
    logic      in_rf_we;
    reg_addr_t in_rf_waddr;
    pc_t       in_pc;
    logic      wb_valid;
    logic      wb_ready;
    logic      wb_rf_we;
    reg_addr_t wb_rf_waddr;
    word_t     wb_rf_wdata;
    pc_t       wb_pc;

    word_t     shadow [0:`PIPE_DMEM_WORDS-1];
    word_t     st_addr [0:N_STORE-1];
    wb_rec_t   exp_q[$];
    string     name_q[$];
    string     test_name;
    wb_rec_t   acc_rec;
    word_t     acc_addr;
    wb_rec_t   rec;
    string     rec_name;
    logic      lat_check;
    logic      bp_mode;
    logic      stalled;
    logic      held_we;
    reg_addr_t held_waddr;
    word_t     held_wdata;
    pc_t       held_pc;
    pc_t       pc_next;
    int        cyc = 0;
    int        seed_init;

    exec_pipe_top i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    always @(posedge clk) cyc <= cyc + 1;

    // expected alu result straight from the operation definitions
    function automatic word_t ref_alu(input alu_op_t op, input word_t a, input word_t b);
        word_t r;
        r = '0;
        if (op[OP_ADD])       r = a + b;
        else if (op[OP_SUB])  r = a - b;
        else if (op[OP_SLT])  r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        else if (op[OP_SLTU]) r = (a < b) ? 32'd1 : 32'd0;
        else if (op[OP_AND])  r = a & b;
        else if (op[OP_OR])   r = a | b;
        else if (op[OP_NOR])  r = ~(a | b);
        else if (op[OP_XOR])  r = a ^ b;
        else if (op[OP_SLL])  r = a << b[4:0];
        else if (op[OP_SRL])  r = a >> b[4:0];
        else if (op[OP_SRA])  r = word_t'($signed(a) >>> b[4:0]);
        else if (op[OP_LUI])  r = b;
        return r;
    endfunction

    function automatic alu_op_t rand_op();
        return alu_op_t'(1) << $urandom_range(0, `PIPE_ALU_OPS - 1);
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("FAIL %s: expected %0h, actual %0h", name, expected, actual);
            $display("Some tests failed");
            $fatal(1, "value mismatch");
        end
    endtask

    // drive one op and hold it until the pipe takes it
    task automatic send_op(input alu_op_t op, input word_t a, input word_t b,
                           input word_t rkd, input logic ld, input logic st);
        in_valid        <= 1'b1;
        in_alu_op       <= op;
        in_src1         <= a;
        in_src2         <= b;
        in_rkd_value    <= rkd;
        in_res_from_mem <= ld;
        in_mem_we       <= st;
        in_rf_we        <= ld | st | ($urandom_range(0, 3) != 0);
        in_rf_waddr     <= reg_addr_t'($urandom_range(0, 31));
        in_pc           <= pc_next;
        pc_next = pc_next + 4;
        do @(posedge clk); while (!in_allowin);
    endtask

    // model of the accepted stream, shadow ram updated in issue order
    always @(posedge clk) begin
        if (resetn && in_valid && in_allowin) begin
            acc_addr          = ref_alu(in_alu_op, in_src1, in_src2);
            acc_rec.rf_we     = in_rf_we & ~in_mem_we;
            acc_rec.waddr     = in_rf_waddr;
            acc_rec.wdata     = in_res_from_mem ? shadow[acc_addr[9:2]] : acc_addr;
            acc_rec.pc        = in_pc;
            acc_rec.fixed_lat = lat_check;
            acc_rec.acc_cyc   = cyc;
            if (in_mem_we) begin
                shadow[acc_addr[9:2]] = in_rkd_value;
            end
            exp_q.push_back(acc_rec);
            name_q.push_back(test_name);
        end
    end

    // compare each writeback and watch stalled records
    always @(posedge clk) begin
        if (resetn) begin
            if (stalled) begin
                check_value("stall wb_valid", 1, wb_valid);
                check_value("stall wb_rf_we", held_we, wb_rf_we);
                check_value("stall wb_rf_waddr", held_waddr, wb_rf_waddr);
                check_value("stall wb_rf_wdata", held_wdata, wb_rf_wdata);
                check_value("stall wb_pc", held_pc, wb_pc);
            end
            if (wb_valid && wb_ready) begin
                if (exp_q.size() == 0) begin
                    $display("writeback at pc %0h arrived with nothing outstanding", wb_pc);
                    $display("Some tests failed");
                    $fatal(1, "unexpected writeback");
                end
                rec      = exp_q.pop_front();
                rec_name = name_q.pop_front();
                check_value({rec_name, " wb_pc"}, rec.pc, wb_pc);
                check_value({rec_name, " wb_rf_we"}, rec.rf_we, wb_rf_we);
                check_value({rec_name, " wb_rf_waddr"}, rec.waddr, wb_rf_waddr);
                check_value({rec_name, " wb_rf_wdata"}, rec.wdata, wb_rf_wdata);
                if (rec.fixed_lat) begin
                    check_value({rec_name, " latency"}, 2, cyc - rec.acc_cyc);
                end
            end
            stalled    = wb_valid && !wb_ready;
            held_we    = wb_rf_we;
            held_waddr = wb_rf_waddr;
            held_wdata = wb_rf_wdata;
            held_pc    = wb_pc;
        end
    end

    always @(posedge clk) begin
        if (bp_mode) begin
            wb_ready <= $urandom_range(0, 1);
        end
    end

    initial begin
        #((N_OPS * 20 + 100) * CLK_NS);
        $display("pipeline hung with %0d writebacks outstanding", exp_q.size());
        $display("Some tests failed");
        $fatal(1, "timeout");
    end

    initial begin
        int    i;
        int    k;
        word_t a;
        word_t b;
        word_t d;
        seed_init = $urandom(49);
        resetn = 1'b0;
        in_valid = 1'b0;
        in_alu_op = '0;
        in_src1 = '0;
        in_src2 = '0;
        in_rkd_value = '0;
        in_res_from_mem = 1'b0;
        in_mem_we = 1'b0;
        in_rf_we = 1'b0;
        in_rf_waddr = '0;
        in_pc = '0;
        wb_ready = 1'b1;
        test_name = "reset";
        lat_check = 1'b0;
        bp_mode = 1'b0;
        stalled = 1'b0;
        pc_next = 32'h1c00_0000;
        for (i = 0; i < `PIPE_DMEM_WORDS; i++) begin
            shadow[i] = '0;
        end
        repeat (5) @(posedge clk);
        resetn <= 1'b1;
        @(negedge clk);
        check_value("reset in_allowin", 1, in_allowin);
        check_value("reset wb_valid", 0, wb_valid);
        @(posedge clk);

        // back-to-back alu ops, no stall
        test_name <= "alu_ops";
        lat_check <= 1'b1;
        repeat (N_ALU) send_op(rand_op(), $urandom, $urandom, $urandom, 1'b0, 1'b0);
        lat_check <= 1'b0;

        test_name <= "store_load";
        for (i = 0; i < N_STORE; i++) begin
            a = $urandom & 32'hffff_fffc;
            b = $urandom & 32'hffff_fffc;
            st_addr[i] = a + b;
            send_op(ADD_OP, a, b, $urandom, 1'b0, 1'b1);
        end
        // stored addresses first, then mostly unwritten ones
        for (i = 0; i < N_LOAD; i++) begin
            a = (i < N_STORE) ? st_addr[N_STORE-1-i] : ($urandom & 32'hffff_fffc);
            b = $urandom & 32'hffff_fffc;
            send_op(ADD_OP, a - b, b, $urandom, 1'b1, 1'b0);
        end

        test_name <= "back_pressure";
        bp_mode <= 1'b1;
        for (i = 0; i < N_MIX; i++) begin
            k = $urandom_range(0, 3);
            a = st_addr[$urandom_range(0, N_STORE - 1)];
            if (k == 0) send_op(ADD_OP, a, 32'd0, $urandom, 1'b0, 1'b1);
            else if (k == 1) send_op(ADD_OP, a, 32'd0, $urandom, 1'b1, 1'b0);
            else send_op(rand_op(), $urandom, $urandom, $urandom, 1'b0, 1'b0);
            if ($urandom_range(0, 7) == 0) begin
                in_valid <= 1'b0;
                @(posedge clk);
            end
        end
        in_valid <= 1'b0;
        bp_mode <= 1'b0;
        @(posedge clk);
        wb_ready <= 1'b1;
        while (exp_q.size() != 0) @(posedge clk);

        // store then load to one address, writeback held off
        test_name <= "store_load_stall";
        wb_ready <= 1'b0;
        a = st_addr[0];
        d = $urandom;
        send_op(ADD_OP, a, 32'd0, d, 1'b0, 1'b1);
        send_op(ADD_OP, a, 32'd0, $urandom, 1'b1, 1'b0);
        in_valid <= 1'b0;
        repeat (4) @(posedge clk);
        wb_ready <= 1'b1;

        while (exp_q.size() != 0) @(posedge clk);
        repeat (3) @(posedge clk);
        if (exp_q.size() == 0) begin
            $display("All tests passed");
            $finish;
        end else begin
            $display("%0d expected writebacks never appeared", exp_q.size());
            $display("Some tests failed");
            $fatal(1, "missing writebacks");
        end
    end

endmodule

//--- verilog.f
+incdir+logic
logic/alu_pkg.sv
logic/pipe_pkg.sv
logic/es_ms_if.sv
logic/alu.sv
logic/data_ram.sv
logic/ex_stage.sv
logic/mem_stage.sv
logic/exec_pipe_top.sv
verif/tb_exec_pipe.sv
